// ==== Bender.yml ====
package:
  name: execute_core

sources:
  - verilog/exePkg.sv
  - verilog/alu.sv
  - verilog/seqMultiplier.sv
  - verilog/forwardUnit.sv
  - verilog/executeStage.sv
  - verilog/memWbStage.sv
  - verilog/executeCore.sv
  - target: test
    files:
      - testbench/executeCoreTb.sv

// ==== src.f ====
verilog/exePkg.sv
verilog/alu.sv
verilog/seqMultiplier.sv
verilog/forwardUnit.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/executeCore.sv
testbench/executeCoreTb.sv

// ==== testbench/executeCoreTb.sv ====
`default_nettype none

module executeCoreTb;
    import exePkg::*;

    localparam int stallLimit = multSteps * 4;

    typedef struct packed {
        logic [31:0] due;
        regIdx       dest;
        word         value;
    } wbEntry;

    logic        clk;
    logic        rstN;
    decodeBundle decodeIn;
    logic        flushE;
    logic        stallD;
    logic        multDone;
    word         resultW;
    regIdx       writeRegW;
    logic        regWriteW;

    // Architectural state in program order and the register file contents
    word    archRegs [32];
    word    shadowRegs [32];
    word    modelMem [dataDepth];
    wbEntry pending [$];
    int     cycle;
    int     errors;
    int     checks;
    int     stallCount;
    int     expectStall;
    logic   prevDone;

    executeCore u_executeCore (
        .clk       (clk),
        .rstN      (rstN),
        .decodeIn  (decodeIn),
        .flushE    (flushE),
        .stallD    (stallD),
        .multDone  (multDone),
        .resultW   (resultW),
        .writeRegW (writeRegW),
        .regWriteW (regWriteW)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string name, input word expected, input word actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %s expected 0x%h got 0x%h at cycle %0d",
                     name, expected, actual, cycle);
        end
    endtask

    function automatic word modelAlu(input aluOp op, input word a, input word b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return ~(a | b);
        endcase
    endfunction

    // Advance to the next falling edge and compare the writeback port with any entry due
    task automatic step();
        wbEntry head;
        @(negedge clk);
        cycle++;
        if (prevDone) begin
            checkValue("multDone", 32'd0, word'(multDone));
        end
        if (multDone) begin
            checkValue("stallD", 32'd0, word'(stallD));
        end
        prevDone = multDone;
        if (pending.size() != 0 && pending[0].due == cycle) begin
            head = pending.pop_front();
            checkValue("regWriteW", 32'd1, word'(regWriteW));
            checkValue("writeRegW", word'(head.dest), word'(writeRegW));
            checkValue("resultW", head.value, resultW);
            // Register file write lands before the decode read
            if (head.dest != '0) begin
                shadowRegs[head.dest] = head.value;
            end
        end else begin
            checkValue("regWriteW", 32'd0, word'(regWriteW));
        end
    endtask

    // Presents a bundle and holds it until the E register takes it
    task automatic issue(input decodeBundle b, input logic writes, input regIdx dest,
                         input word value);
        wbEntry entry;
        step();
        b.rd1    = shadowRegs[b.rs];
        b.rd2    = shadowRegs[b.rt];
        decodeIn = b;
        flushE   = 1'b0;
        stallCount = 0;
        while (stallD && stallCount < stallLimit) begin
            step();
            stallCount++;
        end
        if (stallD) begin
            errors++;
            $display("Timed out waiting for the multiply stall to clear at cycle %0d", cycle);
        end
        checkValue("stallD cycles", word'(expectStall), word'(stallCount));
        checkValue("multDone at release", word'(expectStall != 0), word'(multDone));
        expectStall = 0;
        if (writes) begin
            entry.due   = cycle + 3;
            entry.dest  = dest;
            entry.value = value;
            pending.push_back(entry);
        end
    endtask

    task automatic flushIssue(input decodeBundle b);
        step();
        b.rd1    = shadowRegs[b.rs];
        b.rd2    = shadowRegs[b.rt];
        decodeIn = b;
        flushE   = 1'b1;
    endtask

    function automatic decodeBundle aluInstr(input aluOp op, input srcSel src, input logic dstRd,
                                             input regIdx rs, input regIdx rt, input regIdx rd,
                                             input logic [15:0] imm);
        decodeBundle b;
        b             = '0;
        b.regWrite    = 1'b1;
        b.regDst      = dstRd;
        b.aluSrc      = src;
        b.wbSrc       = wbAlu;
        b.aluOp       = op;
        b.rs          = rs;
        b.rt          = rt;
        b.rd          = rd;
        b.signImm     = {{16{imm[15]}}, imm};
        b.unsignedImm = {16'b0, imm};
        return b;
    endfunction

    task automatic executeAlu(input decodeBundle b);
        word   opB;
        word   value;
        regIdx dest;
        case (b.aluSrc)
            srcSignImm:     opB = b.signImm;
            srcUnsignedImm: opB = b.unsignedImm;
            default:        opB = archRegs[b.rt];
        endcase
        value = modelAlu(b.aluOp, archRegs[b.rs], opB);
        dest  = b.regDst ? b.rd : b.rt;
        if (dest != '0) begin
            archRegs[dest] = value;
        end
        issue(b, 1'b1, dest, value);
    endtask

    task automatic randomAlu();
        aluOp ops [6];
        ops = '{aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluNor};
        executeAlu(aluInstr(ops[$urandom % 6], srcSel'($urandom % 3), 1'($urandom),
                            regIdx'($urandom % 8), regIdx'($urandom % 8),
                            regIdx'($urandom % 8), 16'($urandom)));
    endtask

    // Multiply and move hi and lo out through the result path
    task automatic multiplyAndMove(input regIdx rs, input regIdx rt, input logic isSigned,
                                   input regIdx hiDest, input regIdx loDest);
        decodeBundle b;
        logic [63:0] prod;
        word         a;
        word         c;
        a = archRegs[rs];
        c = archRegs[rt];
        if (isSigned) begin
            prod = $signed({{32{a[31]}}, a}) * $signed({{32{c[31]}}, c});
        end else begin
            prod = {32'b0, a} * {32'b0, c};
        end
        b            = '0;
        b.multStart  = 1'b1;
        b.multSigned = isSigned;
        b.rs         = rs;
        b.rt         = rt;
        issue(b, 1'b0, '0, '0);
        b        = '0;
        b.regWrite = 1'b1;
        b.regDst = 1'b1;
        b.rd     = hiDest;
        b.wbSrc  = wbHi;
        expectStall = multSteps + 1;
        issue(b, 1'b1, hiDest, prod[63:32]);
        archRegs[hiDest] = prod[63:32];
        b.rd    = loDest;
        b.wbSrc = wbLo;
        issue(b, 1'b1, loDest, prod[31:0]);
        archRegs[loDest] = prod[31:0];
    endtask

    task automatic storeThenLoad(input regIdx base, input regIdx data, input regIdx dest,
                                 input ramAddr addr);
        decodeBundle b;
        b          = '0;
        b.memWrite = 1'b1;
        b.aluSrc   = srcSignImm;
        b.aluOp    = aluAdd;
        b.rs       = base;
        b.rt       = data;
        // Offset chosen so that base plus offset lands on the word address
        b.signImm  = {24'b0, addr, 2'b00} - archRegs[base];
        modelMem[addr] = archRegs[data];
        issue(b, 1'b0, '0, '0);
        b.memWrite = 1'b0;
        b.regWrite = 1'b1;
        b.wbSrc    = wbLoad;
        b.rt       = dest;
        if (dest != '0) begin
            archRegs[dest] = modelMem[addr];
        end
        issue(b, 1'b1, dest, modelMem[addr]);
        // Load data is not forwarded from M
        issue('0, 1'b0, '0, '0);
    endtask

    initial begin
        void'($urandom(32'h3497));
        rstN        = 1'b0;
        decodeIn    = '0;
        flushE      = 1'b0;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        stallCount  = 0;
        expectStall = 0;
        prevDone    = 1'b0;
        for (int k = 0; k < 32; k++) begin
            archRegs[k]   = (k == 0) ? '0 : word'($urandom);
            shadowRegs[k] = archRegs[k];
        end

        repeat (5) step();
        rstN = 1'b1;
        step();
        checkValue("stallD", 32'd0, word'(stallD));
        checkValue("multDone", 32'd0, word'(multDone));

        // Dependent chain through M then W
        executeAlu(aluInstr(aluAdd, srcReg, 1'b1, 5'd2, 5'd3, 5'd1, 16'h0));
        executeAlu(aluInstr(aluSub, srcReg, 1'b1, 5'd1, 5'd2, 5'd4, 16'h0));
        executeAlu(aluInstr(aluOr, srcReg, 1'b1, 5'd3, 5'd1, 5'd5, 16'h0));
        executeAlu(aluInstr(aluSlt, srcReg, 1'b1, 5'd4, 5'd5, 5'd6, 16'h0));

        // r0 written and then read at both forwarding distances
        executeAlu(aluInstr(aluAdd, srcSignImm, 1'b0, 5'd1, 5'd0, 5'd0, 16'h8123));
        executeAlu(aluInstr(aluAdd, srcReg, 1'b1, 5'd0, 5'd3, 5'd6, 16'h0));
        executeAlu(aluInstr(aluOr, srcReg, 1'b1, 5'd0, 5'd0, 5'd7, 16'h0));

        repeat (80) randomAlu();

        for (int k = 0; k < 4; k++) begin
            randomAlu();
            multiplyAndMove(regIdx'(1 + $urandom % 7), regIdx'(1 + $urandom % 7), k[0],
                            regIdx'(1 + $urandom % 7), regIdx'(1 + $urandom % 7));
            randomAlu();
        end

        for (int k = 0; k < 4; k++) begin
            randomAlu();
            storeThenLoad(regIdx'($urandom % 8), regIdx'(1 + $urandom % 7),
                          regIdx'(1 + $urandom % 7), ramAddr'($urandom));
        end

        // Flushed bundle must never write back
        randomAlu();
        flushIssue(aluInstr(aluAdd, srcReg, 1'b1, 5'd1, 5'd2, 5'd7, 16'h0));
        repeat (3) issue('0, 1'b0, '0, '0);
        executeAlu(aluInstr(aluOr, srcReg, 1'b1, 5'd7, 5'd0, 5'd3, 16'h0));

        repeat (4) issue('0, 1'b0, '0, '0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu (
    input  exePkg::word  a,
    input  exePkg::word  b,
    input  exePkg::aluOp op,
    output exePkg::word  y,
    output logic         zero
);
    import exePkg::*;

    always_comb begin
        unique case (op)
            aluAdd: y = a + b;
            aluSub: y = a - b;
            aluAnd: y = a & b;
            aluOr:  y = a | b;
            // Signed compare, result in bit 0
            aluSlt: y = {31'b0, $signed(a) < $signed(b)};
            aluNor: y = ~(a | b);
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== verilog/exePkg.sv ====
`default_nettype none

package exePkg;

    // Datapath widths
    typedef logic [31:0] word;
    typedef logic [4:0]  regIdx;

    localparam int multSteps = 32;
    localparam int dataDepth = 64;

    // Multiplier step counter
    typedef logic [$clog2(multSteps)-1:0] stepCount;
    localparam stepCount lastStep = stepCount'(multSteps - 1);

    // Data RAM word address
    typedef logic [$clog2(dataDepth)-1:0] ramAddr;

    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluNor = 3'b100,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOp;

    // Operand source after forwarding
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSel;

    // Operand B source
    typedef logic [1:0] srcSel;
    localparam srcSel srcReg         = 2'b00;
    localparam srcSel srcSignImm     = 2'b01;
    localparam srcSel srcUnsignedImm = 2'b10;

    // Result select, top bit picks the multiplier and the middle bit hi over lo
    typedef logic [2:0] wbSrc;
    localparam wbSrc wbAlu  = 3'b000;
    localparam wbSrc wbLoad = 3'b001;
    localparam wbSrc wbLo   = 3'b100;
    localparam wbSrc wbHi   = 3'b110;

    typedef enum logic [1:0] {
        multIdle,
        multRun,
        multFix
    } multState;

    typedef struct packed {
        logic  multStart;
        logic  multSigned;
        logic  regWrite;
        logic  memWrite;
        logic  regDst;
        logic  jump;
        srcSel aluSrc;
        wbSrc  wbSrc;
        aluOp  aluOp;
        regIdx rs;
        regIdx rt;
        regIdx rd;
        word   rd1;
        word   rd2;
        word   signImm;
        word   unsignedImm;
        word   pcPlus4;
    } decodeBundle;

    typedef struct packed {
        logic  jump;
        logic  regWrite;
        logic  memWrite;
        wbSrc  wbSrc;
        regIdx writeReg;
        word   result;
        word   writeData;
        word   pcPlus4;
    } execBundle;

endpackage

`default_nettype wire

// ==== verilog/executeCore.sv ====
`default_nettype none

module executeCore (
    input  logic                clk,
    input  logic                rstN,
    input  exePkg::decodeBundle decodeIn,
    input  logic                flushE,
    output logic                stallD,
    output logic                multDone,
    output exePkg::word         resultW,
    output exePkg::regIdx       writeRegW,
    output logic                regWriteW
);
    import exePkg::*;

    execBundle execOut;
    regIdx     rsE;
    regIdx     rtE;
    regIdx     writeRegM;
    logic      regWriteM;
    word       aluOutM;
    fwdSel     forwardA;
    fwdSel     forwardB;
    logic      multBusy;
    logic      stall;

    executeStage u_executeStage (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (flushE),
        .stall    (stall),
        .decodeIn (decodeIn),
        .forwardA (forwardA),
        .forwardB (forwardB),
        .aluOutM  (aluOutM),
        .resultW  (resultW),
        .execOut  (execOut),
        .rsE      (rsE),
        .rtE      (rtE),
        .multBusy (multBusy),
        .multDone (multDone)
    );

    forwardUnit u_forwardUnit (
        .rsE       (rsE),
        .rtE       (rtE),
        .writeRegM (writeRegM),
        .regWriteM (regWriteM),
        .writeRegW (writeRegW),
        .regWriteW (regWriteW),
        .multBusy  (multBusy),
        .multDone  (multDone),
        .forwardA  (forwardA),
        .forwardB  (forwardB),
        .stall     (stall)
    );

    // Held E slot must not reach M a second time
    memWbStage u_memWbStage (
        .clk       (clk),
        .rstN      (rstN),
        .bubble    (stall),
        .execOut   (execOut),
        .aluOutM   (aluOutM),
        .writeRegM (writeRegM),
        .regWriteM (regWriteM),
        .resultW   (resultW),
        .writeRegW (writeRegW),
        .regWriteW (regWriteW)
    );

    assign stallD = stall;

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`default_nettype none

module executeStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                flush,
    input  logic                stall,
    input  exePkg::decodeBundle decodeIn,
    input  exePkg::fwdSel       forwardA,
    input  exePkg::fwdSel       forwardB,
    input  exePkg::word         aluOutM,
    input  exePkg::word         resultW,
    output exePkg::execBundle   execOut,
    output exePkg::regIdx       rsE,
    output exePkg::regIdx       rtE,
    output logic                multBusy,
    output logic                multDone
);
    import exePkg::*;

    decodeBundle regE;
    word         srcA;
    word         fwdB;
    word         srcB;
    word         aluA;
    word         aluB;
    word         aluY;
    aluOp        aluFn;
    word         mulA;
    word         mulB;
    word         hi;
    word         lo;
    logic        mulBusy;
    logic        mulStart;

    // Pipeline register, flush wins over stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regE <= '0;
        end else if (flush) begin
            regE <= '0;
        end else if (!stall) begin
            regE <= decodeIn;
        end
    end

    always_comb begin
        unique case (forwardA)
            fwdMem:  srcA = aluOutM;
            fwdWb:   srcA = resultW;
            default: srcA = regE.rd1;
        endcase
    end

    always_comb begin
        unique case (forwardB)
            fwdMem:  fwdB = aluOutM;
            fwdWb:   fwdB = resultW;
            default: fwdB = regE.rd2;
        endcase
    end

    always_comb begin
        case (regE.aluSrc)
            srcReg:         srcB = fwdB;
            srcSignImm:     srcB = regE.signImm;
            srcUnsignedImm: srcB = regE.unsignedImm;
            default:        srcB = fwdB;
        endcase
    end

    // Multiplier owns the ALU while running
    assign aluA  = mulBusy ? mulA : srcA;
    assign aluB  = mulBusy ? mulB : srcB;
    assign aluFn = mulBusy ? aluAdd : regE.aluOp;

    alu u_alu (
        .a    (aluA),
        .b    (aluB),
        .op   (aluFn),
        .y    (aluY),
        .zero ()
    );

    assign mulStart = regE.multStart && !mulBusy;

    seqMultiplier u_seqMultiplier (
        .clk      (clk),
        .rstN     (rstN),
        .start    (mulStart),
        .signedOp (regE.multSigned),
        .srcA     (srcA),
        .srcB     (srcB),
        .aluY     (aluY),
        .aluA     (mulA),
        .aluB     (mulB),
        .busy     (mulBusy),
        .done     (multDone),
        .hi       (hi),
        .lo       (lo)
    );

    // Start cycle counts as busy so the E register holds from the first cycle
    assign multBusy = mulBusy || mulStart;

    assign rsE = regE.rs;
    assign rtE = regE.rt;

    assign execOut.jump      = regE.jump;
    assign execOut.regWrite  = regE.regWrite;
    assign execOut.memWrite  = regE.memWrite;
    assign execOut.wbSrc     = regE.wbSrc;
    assign execOut.writeReg  = regE.regDst ? regE.rd : regE.rt;
    assign execOut.result    = regE.wbSrc[2] ? (regE.wbSrc[1] ? hi : lo) : aluY;
    assign execOut.writeData = fwdB;
    assign execOut.pcPlus4   = regE.pcPlus4;

endmodule

`default_nettype wire

// ==== verilog/forwardUnit.sv ====
`default_nettype none

module forwardUnit (
    input  exePkg::regIdx rsE,
    input  exePkg::regIdx rtE,
    input  exePkg::regIdx writeRegM,
    input  logic          regWriteM,
    input  exePkg::regIdx writeRegW,
    input  logic          regWriteW,
    input  logic          multBusy,
    input  logic          multDone,
    output exePkg::fwdSel forwardA,
    output exePkg::fwdSel forwardB,
    output logic          stall
);
    import exePkg::*;

    // Memory result is newer, so it is checked first
    function automatic fwdSel pickPath(input regIdx src, input regIdx regM, input logic wrM,
                                       input regIdx regW, input logic wrW);
        fwdSel sel;
        sel = fwdReg;
        if (wrM && regM != '0 && regM == src) begin
            sel = fwdMem;
        end else if (wrW && regW != '0 && regW == src) begin
            sel = fwdWb;
        end
        return sel;
    endfunction

    assign forwardA = pickPath(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
    assign forwardB = pickPath(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

    // Released in the cycle hi/lo are loaded
    assign stall = multBusy && !multDone;

endmodule

`default_nettype wire

// ==== verilog/memWbStage.sv ====
`default_nettype none

module memWbStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              bubble,
    input  exePkg::execBundle execOut,
    output exePkg::word       aluOutM,
    output exePkg::regIdx     writeRegM,
    output logic              regWriteM,
    output exePkg::word       resultW,
    output exePkg::regIdx     writeRegW,
    output logic              regWriteW
);
    import exePkg::*;

    execBundle regM;
    execBundle nextM;
    word       ram [dataDepth];
    ramAddr    addrM;
    word       readData;

    // Bubble keeps the payload but kills every side effect
    always_comb begin
        nextM = execOut;
        if (bubble) begin
            nextM.jump     = 1'b0;
            nextM.regWrite = 1'b0;
            nextM.memWrite = 1'b0;
            nextM.wbSrc    = wbAlu;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regM <= '0;
        end else begin
            regM <= nextM;
        end
    end

    // Word address from the ALU result
    assign addrM    = regM.result[$clog2(dataDepth)+1:2];
    assign readData = ram[addrM];

    always_ff @(posedge clk) begin
        if (regM.memWrite) begin
            ram[addrM] <= regM.writeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
            writeRegW <= '0;
        end else begin
            regWriteW <= regM.regWrite;
            writeRegW <= regM.writeReg;
        end
    end

    always_ff @(posedge clk) begin
        resultW <= (regM.wbSrc == wbLoad) ? readData : regM.result;
    end

    assign aluOutM   = regM.result;
    assign writeRegM = regM.writeReg;
    assign regWriteM = regM.regWrite;

endmodule

`default_nettype wire

// ==== verilog/seqMultiplier.sv ====
`default_nettype none

module seqMultiplier (
    input  logic        clk,
    input  logic        rstN,
    input  logic        start,
    input  logic        signedOp,
    input  exePkg::word srcA,
    input  exePkg::word srcB,
    input  exePkg::word aluY,
    output exePkg::word aluA,
    output exePkg::word aluB,
    output logic        busy,
    output logic        done,
    output exePkg::word hi,
    output exePkg::word lo
);
    import exePkg::*;

    multState    state;
    stepCount    stepCnt;
    word         mcand;
    word         magA;
    word         magB;
    logic [63:0] acc;
    logic [63:0] product;
    logic        negRes;
    logic        carry;

    // Work on magnitudes, sign is restored in fix
    assign magA = (signedOp && srcA[31]) ? -srcA : srcA;
    assign magB = (signedOp && srcB[31]) ? -srcB : srcB;

    // Upper half plus multiplicand, or plus zero when the bit is clear
    assign aluA = acc[63:32];
    assign aluB = acc[0] ? mcand : '0;

    // Sum wrapped below the addend, so the add carried out
    assign carry = (aluY < acc[63:32]);

    assign product = negRes ? -acc : acc;
    assign busy    = (state != multIdle);
    assign done    = (state == multFix);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= multIdle;
            stepCnt <= '0;
            hi      <= '0;
            lo      <= '0;
        end else begin
            unique case (state)
                multIdle: begin
                    if (start) begin
                        state   <= multRun;
                        stepCnt <= '0;
                    end
                end
                multRun: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == lastStep) begin
                        state <= multFix;
                    end
                end
                multFix: begin
                    hi    <= product[63:32];
                    lo    <= product[31:0];
                    state <= multIdle;
                end
                default: state <= multIdle;
            endcase
        end
    end

    // Accumulator holds partial sum above and remaining multiplier bits below
    always_ff @(posedge clk) begin
        if (state == multIdle && start) begin
            mcand  <= magA;
            acc    <= {32'b0, magB};
            negRes <= signedOp && (srcA[31] ^ srcB[31]);
        end else if (state == multRun) begin
            acc <= {carry, aluY, acc[31:1]};
        end
    end

endmodule

`default_nettype wire
